/* hw/core_pkg.sv */
/*
  Shared definitions for the RV32I core
  - data, address and register index widths
  - major opcode enum and funct3 constants
  - operand select, ALU op and immediate format enums
  - gen_imm immediate builder
*/
`default_nettype none

package core_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] pc_t;
  typedef logic [31:0]     instr_raw_t;
  typedef logic [XLEN-1:0] rdata_t;
  typedef logic [4:0]      raddr_t;
  typedef logic [XLEN-1:0] imm_t;
  typedef logic [2:0]      funct3_t;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    RV_LOAD     = 7'b0000011,
    RV_MISC_MEM = 7'b0001111,
    RV_OP_IMM   = 7'b0010011,
    RV_AUIPC    = 7'b0010111,
    RV_STORE    = 7'b0100011,
    RV_OP       = 7'b0110011,
    RV_LUI      = 7'b0110111,
    RV_BRANCH   = 7'b1100011,
    RV_JALR     = 7'b1100111,
    RV_JAL      = 7'b1101111,
    RV_SYSTEM   = 7'b1110011
  } opcode_t;

  // ALU funct3 encodings
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // Branch funct3 encodings
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // Where an ALU operand comes from
  typedef enum logic [1:0] {
    REG_RF,
    IMM,
    PC,
    ZERO
  } op_sel_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  typedef enum logic [2:0] {
    I_IMM,
    S_IMM,
    B_IMM,
    U_IMM,
    J_IMM
  } imm_fmt_t;

  // Sign-extended immediate of the given format
  function automatic imm_t gen_imm(instr_raw_t instr, imm_fmt_t fmt);
    imm_t imm;
    case (fmt)
      I_IMM:   imm = {{20{instr[31]}}, instr[31:20]};
      S_IMM:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      B_IMM:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                      instr[11:8], 1'b0};
      U_IMM:   imm = {instr[31:12], 12'b0};
      J_IMM:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                      instr[30:21], 1'b0};
      default: imm = '0;
    endcase
    return imm;
  endfunction

endpackage

`default_nettype wire

/* hw/register_file.sv */
/*
  32 x 32-bit integer register file
  Two combinational read ports, one synchronous write port
  x0 reads as zero, writes pass through to the read ports
*/
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic             clk,
  input  logic             rst_i,
  input  core_pkg::raddr_t rs1_addr_i,
  input  core_pkg::raddr_t rs2_addr_i,
  input  core_pkg::raddr_t rd_addr_i,
  input  core_pkg::rdata_t rd_data_i,
  input  logic             we_i,
  output core_pkg::rdata_t rs1_data_o,
  output core_pkg::rdata_t rs2_data_o
);
  import core_pkg::*;

  rdata_t regs_q [32];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (rd_addr_i != '0)) begin
      regs_q[rd_addr_i] <= rd_data_i;
    end
  end

  // Same-cycle write bypass, x0 always zero
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 :
                      (we_i && (rd_addr_i == rs1_addr_i)) ? rd_data_i : regs_q[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 :
                      (we_i && (rd_addr_i == rs2_addr_i)) ? rd_data_i : regs_q[rs2_addr_i];

endmodule

`default_nettype wire

/* hw/decode.sv */
/*
  Decode stage
  - running PC and redirect handling
  - instruction decode into operand selects, ALU op and immediate
  - RAW interlock against execute and writeback
  - ID/EX pipeline register and the register file
*/
`timescale 1ns/1ps
`default_nettype none

module decode #(
  parameter core_pkg::pc_t RESET_PC = '0
) (
  input  logic                 clk,
  input  logic                 rst_i,
  // Fetch port
  input  logic                 fetch_valid_i,
  output logic                 fetch_ready_o,
  input  core_pkg::instr_raw_t fetch_instr_i,
  // To execute
  output logic                 id_valid_o,
  input  logic                 id_ready_i,
  output core_pkg::pc_t        id_pc_o,
  output core_pkg::rdata_t     id_rs1_data_o,
  output core_pkg::rdata_t     id_rs2_data_o,
  output core_pkg::op_sel_t    id_rs1_op_o,
  output core_pkg::op_sel_t    id_rs2_op_o,
  output core_pkg::alu_op_t    id_alu_op_o,
  output core_pkg::imm_t       id_imm_o,
  output core_pkg::raddr_t     id_rd_o,
  output logic                 id_we_o,
  output logic                 id_branch_o,
  output logic                 id_jump_o,
  output logic                 id_jalr_o,
  output core_pkg::funct3_t    id_f3_o,
  output logic                 id_trap_o,
  // Redirect from execute
  input  logic                 redirect_i,
  input  core_pkg::pc_t        redirect_pc_i,
  // Pending destinations
  input  logic                 ex_pend_valid_i,
  input  core_pkg::raddr_t     ex_pend_rd_i,
  input  logic                 ex_pend_we_i,
  input  logic                 wb_pend_valid_i,
  input  core_pkg::raddr_t     wb_pend_rd_i,
  input  logic                 wb_pend_we_i,
  // Register file write port
  input  logic                 wb_we_i,
  input  core_pkg::raddr_t     wb_rd_i,
  input  core_pkg::rdata_t     wb_data_i
);
  import core_pkg::*;

  pc_t      pc_q;
  funct3_t  f3;
  raddr_t   rs1_addr;
  raddr_t   rs2_addr;
  op_sel_t  dec_rs1_op;
  op_sel_t  dec_rs2_op;
  alu_op_t  dec_alu_op;
  imm_t     dec_imm;
  logic     dec_we;
  logic     dec_branch;
  logic     dec_jump;
  logic     dec_jalr;
  logic     dec_trap;
  rdata_t   rf_rs1_data;
  rdata_t   rf_rs2_data;
  logic     rs1_hit;
  logic     rs2_hit;
  logic     fetch_fire;

  assign f3       = funct3_t'(fetch_instr_i[14:12]);
  assign rs1_addr = raddr_t'(fetch_instr_i[19:15]);
  assign rs2_addr = raddr_t'(fetch_instr_i[24:20]);

  // funct3 to ALU op, bit 30 picks SUB (OP only) and SRA
  function automatic alu_op_t alu_from_f3(funct3_t fn, logic b30, logic is_op);
    alu_op_t op;
    case (fn)
      F3_ADD_SUB: op = (b30 && is_op) ? ALU_SUB : ALU_ADD;
      F3_SLL:     op = ALU_SLL;
      F3_SLT:     op = ALU_SLT;
      F3_SLTU:    op = ALU_SLTU;
      F3_XOR:     op = ALU_XOR;
      F3_SRL_SRA: op = b30 ? ALU_SRA : ALU_SRL;
      F3_OR:      op = ALU_OR;
      F3_AND:     op = ALU_AND;
      default:    op = ALU_ADD;
    endcase
    return op;
  endfunction

  always_comb begin
    dec_rs1_op = ZERO;
    dec_rs2_op = ZERO;
    dec_alu_op = ALU_ADD;
    dec_imm    = '0;
    dec_we     = 1'b0;
    dec_branch = 1'b0;
    dec_jump   = 1'b0;
    dec_jalr   = 1'b0;
    dec_trap   = 1'b0;
    case (opcode_t'(fetch_instr_i[6:0]))
      RV_OP_IMM: begin
        dec_rs1_op = REG_RF;
        dec_rs2_op = IMM;
        dec_alu_op = alu_from_f3(f3, fetch_instr_i[30], 1'b0);
        dec_imm    = gen_imm(fetch_instr_i, I_IMM);
        dec_we     = 1'b1;
      end
      RV_OP: begin
        dec_rs1_op = REG_RF;
        dec_rs2_op = REG_RF;
        dec_alu_op = alu_from_f3(f3, fetch_instr_i[30], 1'b1);
        dec_we     = 1'b1;
      end
      RV_LUI: begin
        dec_rs2_op = IMM;
        dec_imm    = gen_imm(fetch_instr_i, U_IMM);
        dec_we     = 1'b1;
      end
      RV_AUIPC: begin
        dec_rs1_op = PC;
        dec_rs2_op = IMM;
        dec_imm    = gen_imm(fetch_instr_i, U_IMM);
        dec_we     = 1'b1;
      end
      RV_JAL: begin
        dec_rs1_op = PC;
        dec_rs2_op = IMM;
        dec_imm    = gen_imm(fetch_instr_i, J_IMM);
        dec_we     = 1'b1;
        dec_jump   = 1'b1;
      end
      RV_JALR: begin
        dec_rs1_op = REG_RF;
        dec_rs2_op = IMM;
        dec_imm    = gen_imm(fetch_instr_i, I_IMM);
        dec_we     = 1'b1;
        dec_jump   = 1'b1;
        dec_jalr   = 1'b1;
      end
      RV_BRANCH: begin
        dec_rs1_op = REG_RF;
        dec_rs2_op = REG_RF;
        dec_imm    = gen_imm(fetch_instr_i, B_IMM);
        dec_branch = 1'b1;
      end
      // Fence and system retire as no-ops
      RV_MISC_MEM, RV_SYSTEM: begin
      end
      // No data memory, loads and stores trap like unknown opcodes
      default: begin
        dec_trap = 1'b1;
      end
    endcase
  end

  // Interlock on sources still owned by execute or writeback
  assign rs1_hit = (dec_rs1_op == REG_RF) && (rs1_addr != '0) &&
                   ((ex_pend_valid_i && ex_pend_we_i && (ex_pend_rd_i == rs1_addr)) ||
                    (wb_pend_valid_i && wb_pend_we_i && (wb_pend_rd_i == rs1_addr)));
  assign rs2_hit = (dec_rs2_op == REG_RF) && (rs2_addr != '0) &&
                   ((ex_pend_valid_i && ex_pend_we_i && (ex_pend_rd_i == rs2_addr)) ||
                    (wb_pend_valid_i && wb_pend_we_i && (wb_pend_rd_i == rs2_addr)));

  assign fetch_ready_o = (!id_valid_o || id_ready_i) && !rs1_hit && !rs2_hit;
  assign fetch_fire    = fetch_valid_i && fetch_ready_o;

  // A word taken during a redirect is on the wrong path
  always_ff @(posedge clk) begin
    if (rst_i) begin
      id_valid_o <= 1'b0;
      pc_q       <= RESET_PC;
    end else if (redirect_i) begin
      id_valid_o <= 1'b0;
      pc_q       <= redirect_pc_i;
    end else if (fetch_fire) begin
      id_valid_o <= 1'b1;
      pc_q       <= pc_q + pc_t'(4);
    end else if (id_ready_i) begin
      id_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_fire) begin
      id_pc_o       <= pc_q;
      id_rs1_data_o <= rf_rs1_data;
      id_rs2_data_o <= rf_rs2_data;
      id_rs1_op_o   <= dec_rs1_op;
      id_rs2_op_o   <= dec_rs2_op;
      id_alu_op_o   <= dec_alu_op;
      id_imm_o      <= dec_imm;
      id_rd_o       <= raddr_t'(fetch_instr_i[11:7]);
      id_we_o       <= dec_we;
      id_branch_o   <= dec_branch;
      id_jump_o     <= dec_jump;
      id_jalr_o     <= dec_jalr;
      id_f3_o       <= f3;
      id_trap_o     <= dec_trap;
    end
  end

  register_file u_register_file (
    .clk        (clk),
    .rst_i      (rst_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rd_addr_i  (wb_rd_i),
    .rd_data_i  (wb_data_i),
    .we_i       (wb_we_i),
    .rs1_data_o (rf_rs1_data),
    .rs2_data_o (rf_rs2_data)
  );

endmodule

`default_nettype wire

/* hw/execute.sv */
/*
  Execute stage
  - operand selection and ALU
  - branch compare, jump target and redirect
  - link value for JAL and JALR
  - EX/WB pipeline register
*/
`timescale 1ns/1ps
`default_nettype none

module execute (
  input  logic              clk,
  input  logic              rst_i,
  // From decode
  input  logic              id_valid_i,
  output logic              id_ready_o,
  input  core_pkg::pc_t     id_pc_i,
  input  core_pkg::rdata_t  id_rs1_data_i,
  input  core_pkg::rdata_t  id_rs2_data_i,
  input  core_pkg::op_sel_t id_rs1_op_i,
  input  core_pkg::op_sel_t id_rs2_op_i,
  input  core_pkg::alu_op_t id_alu_op_i,
  input  core_pkg::imm_t    id_imm_i,
  input  core_pkg::raddr_t  id_rd_i,
  input  logic              id_we_i,
  input  logic              id_branch_i,
  input  logic              id_jump_i,
  input  logic              id_jalr_i,
  input  core_pkg::funct3_t id_f3_i,
  input  logic              id_trap_i,
  // To writeback
  output logic              ex_valid_o,
  input  logic              ex_ready_i,
  output core_pkg::pc_t     ex_pc_o,
  output core_pkg::raddr_t  ex_rd_o,
  output logic              ex_we_o,
  output core_pkg::rdata_t  ex_result_o,
  output logic              ex_trap_o,
  // Interlock and redirect
  output logic              pend_valid_o,
  output core_pkg::raddr_t  pend_rd_o,
  output logic              pend_we_o,
  output logic              redirect_o,
  output core_pkg::pc_t     redirect_pc_o
);
  import core_pkg::*;

  rdata_t op_a;
  rdata_t op_b;
  rdata_t alu_res;
  rdata_t jalr_sum;
  logic   br_cond;
  logic   take;

  function automatic rdata_t sel_operand(op_sel_t sel, rdata_t rf, imm_t imm, pc_t pc);
    rdata_t val;
    case (sel)
      REG_RF:  val = rf;
      IMM:     val = imm;
      PC:      val = pc;
      default: val = '0;
    endcase
    return val;
  endfunction

  assign op_a = sel_operand(id_rs1_op_i, id_rs1_data_i, id_imm_i, id_pc_i);
  assign op_b = sel_operand(id_rs2_op_i, id_rs2_data_i, id_imm_i, id_pc_i);

  always_comb begin
    case (id_alu_op_i)
      ALU_ADD:  alu_res = op_a + op_b;
      ALU_SUB:  alu_res = op_a - op_b;
      ALU_SLL:  alu_res = op_a << op_b[4:0];
      ALU_SLT:  alu_res = rdata_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU: alu_res = rdata_t'(op_a < op_b);
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_SRL:  alu_res = op_a >> op_b[4:0];
      ALU_SRA:  alu_res = rdata_t'($signed(op_a) >>> op_b[4:0]);
      ALU_OR:   alu_res = op_a | op_b;
      ALU_AND:  alu_res = op_a & op_b;
      default:  alu_res = op_a + op_b;
    endcase
  end

  // Branch condition straight from the register operands
  always_comb begin
    case (id_f3_i)
      F3_BEQ:  br_cond = (id_rs1_data_i == id_rs2_data_i);
      F3_BNE:  br_cond = (id_rs1_data_i != id_rs2_data_i);
      F3_BLT:  br_cond = ($signed(id_rs1_data_i) < $signed(id_rs2_data_i));
      F3_BGE:  br_cond = ($signed(id_rs1_data_i) >= $signed(id_rs2_data_i));
      F3_BLTU: br_cond = (id_rs1_data_i < id_rs2_data_i);
      F3_BGEU: br_cond = (id_rs1_data_i >= id_rs2_data_i);
      default: br_cond = 1'b0;
    endcase
  end

  assign jalr_sum      = id_rs1_data_i + id_imm_i;
  assign redirect_pc_o = id_jalr_i ? {jalr_sum[31:1], 1'b0} : id_pc_i + id_imm_i;

  assign id_ready_o = !ex_valid_o || ex_ready_i;
  assign take       = id_valid_i && id_ready_o;
  // Pulse only as the branch or jump moves on
  assign redirect_o = take && (id_jump_i || (id_branch_i && br_cond));

  assign pend_valid_o = id_valid_i;
  assign pend_rd_o    = id_rd_i;
  assign pend_we_o    = id_we_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ex_valid_o <= 1'b0;
    end else if (take) begin
      ex_valid_o <= 1'b1;
    end else if (ex_ready_i) begin
      ex_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      ex_pc_o     <= id_pc_i;
      ex_rd_o     <= id_rd_i;
      ex_we_o     <= id_we_i;
      ex_result_o <= id_jump_i ? rdata_t'(id_pc_i + pc_t'(4)) : alu_res;
      ex_trap_o   <= id_trap_i;
    end
  end

endmodule

`default_nettype wire

/* hw/writeback.sv */
/*
  Writeback stage
  Register file write as a record enters, retire record register
*/
`timescale 1ns/1ps
`default_nettype none

module writeback (
  input  logic             clk,
  input  logic             rst_i,
  input  logic             ex_valid_i,
  output logic             ex_ready_o,
  input  core_pkg::pc_t    ex_pc_i,
  input  core_pkg::raddr_t ex_rd_i,
  input  logic             ex_we_i,
  input  core_pkg::rdata_t ex_result_i,
  input  logic             ex_trap_i,
  output logic             wb_we_o,
  output core_pkg::raddr_t wb_rd_o,
  output core_pkg::rdata_t wb_data_o,
  output logic             pend_valid_o,
  output core_pkg::raddr_t pend_rd_o,
  output logic             pend_we_o,
  output logic             retire_valid_o,
  input  logic             retire_ready_i,
  output core_pkg::pc_t    retire_pc_o,
  output core_pkg::raddr_t retire_rd_o,
  output logic             retire_we_o,
  output core_pkg::rdata_t retire_data_o,
  output logic             retire_trap_o
);
  import core_pkg::*;

  logic take;

  assign ex_ready_o = !retire_valid_o || retire_ready_i;
  assign take       = ex_valid_i && ex_ready_o;

  // One write per record, never to x0 or on a trap
  assign wb_we_o   = take && ex_we_i && !ex_trap_i && (ex_rd_i != raddr_t'(0));
  assign wb_rd_o   = ex_rd_i;
  assign wb_data_o = ex_result_i;

  // Record held back by retire stall has not written yet
  assign pend_valid_o = ex_valid_i && !ex_ready_o;
  assign pend_rd_o    = ex_rd_i;
  assign pend_we_o    = ex_we_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      retire_valid_o <= 1'b0;
    end else if (take) begin
      retire_valid_o <= 1'b1;
    end else if (retire_ready_i) begin
      retire_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      retire_pc_o   <= ex_pc_i;
      retire_rd_o   <= ex_rd_i;
      retire_we_o   <= wb_we_o;
      retire_data_o <= ex_result_i;
      retire_trap_o <= ex_trap_i;
    end
  end

endmodule

`default_nettype wire

/* hw/core_top.sv */
/*
  RV32I core top level
  Decode, execute and writeback stages with their links
*/
`timescale 1ns/1ps
`default_nettype none

module core_top #(
  parameter core_pkg::pc_t RESET_PC = '0
) (
  input  logic                 clk,
  input  logic                 rst_i,
  input  logic                 fetch_valid_i,
  output logic                 fetch_ready_o,
  input  core_pkg::instr_raw_t fetch_instr_i,
  output logic                 retire_valid_o,
  input  logic                 retire_ready_i,
  output core_pkg::pc_t        retire_pc_o,
  output core_pkg::raddr_t     retire_rd_o,
  output logic                 retire_we_o,
  output core_pkg::rdata_t     retire_data_o,
  output logic                 retire_trap_o,
  output logic                 redirect_o,
  output core_pkg::pc_t        redirect_pc_o
);
  import core_pkg::*;

  // Decode to execute
  logic     id_valid;
  logic     id_ready;
  pc_t      id_pc;
  rdata_t   id_rs1_data;
  rdata_t   id_rs2_data;
  op_sel_t  id_rs1_op;
  op_sel_t  id_rs2_op;
  alu_op_t  id_alu_op;
  imm_t     id_imm;
  raddr_t   id_rd;
  logic     id_we;
  logic     id_branch;
  logic     id_jump;
  logic     id_jalr;
  funct3_t  id_f3;
  logic     id_trap;

  // Execute to writeback
  logic     ex_valid;
  logic     ex_ready;
  pc_t      ex_pc;
  raddr_t   ex_rd;
  logic     ex_we;
  rdata_t   ex_result;
  logic     ex_trap;

  // Side paths
  logic     ex_pend_valid;
  raddr_t   ex_pend_rd;
  logic     ex_pend_we;
  logic     wb_pend_valid;
  raddr_t   wb_pend_rd;
  logic     wb_pend_we;
  logic     wb_we;
  raddr_t   wb_rd;
  rdata_t   wb_data;

  decode #(
    .RESET_PC (RESET_PC)
  ) u_decode (
    .clk             (clk),
    .rst_i           (rst_i),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_ready_o   (fetch_ready_o),
    .fetch_instr_i   (fetch_instr_i),
    .id_valid_o      (id_valid),
    .id_ready_i      (id_ready),
    .id_pc_o         (id_pc),
    .id_rs1_data_o   (id_rs1_data),
    .id_rs2_data_o   (id_rs2_data),
    .id_rs1_op_o     (id_rs1_op),
    .id_rs2_op_o     (id_rs2_op),
    .id_alu_op_o     (id_alu_op),
    .id_imm_o        (id_imm),
    .id_rd_o         (id_rd),
    .id_we_o         (id_we),
    .id_branch_o     (id_branch),
    .id_jump_o       (id_jump),
    .id_jalr_o       (id_jalr),
    .id_f3_o         (id_f3),
    .id_trap_o       (id_trap),
    .redirect_i      (redirect_o),
    .redirect_pc_i   (redirect_pc_o),
    .ex_pend_valid_i (ex_pend_valid),
    .ex_pend_rd_i    (ex_pend_rd),
    .ex_pend_we_i    (ex_pend_we),
    .wb_pend_valid_i (wb_pend_valid),
    .wb_pend_rd_i    (wb_pend_rd),
    .wb_pend_we_i    (wb_pend_we),
    .wb_we_i         (wb_we),
    .wb_rd_i         (wb_rd),
    .wb_data_i       (wb_data)
  );

  execute u_execute (
    .clk           (clk),
    .rst_i         (rst_i),
    .id_valid_i    (id_valid),
    .id_ready_o    (id_ready),
    .id_pc_i       (id_pc),
    .id_rs1_data_i (id_rs1_data),
    .id_rs2_data_i (id_rs2_data),
    .id_rs1_op_i   (id_rs1_op),
    .id_rs2_op_i   (id_rs2_op),
    .id_alu_op_i   (id_alu_op),
    .id_imm_i      (id_imm),
    .id_rd_i       (id_rd),
    .id_we_i       (id_we),
    .id_branch_i   (id_branch),
    .id_jump_i     (id_jump),
    .id_jalr_i     (id_jalr),
    .id_f3_i       (id_f3),
    .id_trap_i     (id_trap),
    .ex_valid_o    (ex_valid),
    .ex_ready_i    (ex_ready),
    .ex_pc_o       (ex_pc),
    .ex_rd_o       (ex_rd),
    .ex_we_o       (ex_we),
    .ex_result_o   (ex_result),
    .ex_trap_o     (ex_trap),
    .pend_valid_o  (ex_pend_valid),
    .pend_rd_o     (ex_pend_rd),
    .pend_we_o     (ex_pend_we),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o)
  );

  writeback u_writeback (
    .clk            (clk),
    .rst_i          (rst_i),
    .ex_valid_i     (ex_valid),
    .ex_ready_o     (ex_ready),
    .ex_pc_i        (ex_pc),
    .ex_rd_i        (ex_rd),
    .ex_we_i        (ex_we),
    .ex_result_i    (ex_result),
    .ex_trap_i      (ex_trap),
    .wb_we_o        (wb_we),
    .wb_rd_o        (wb_rd),
    .wb_data_o      (wb_data),
    .pend_valid_o   (wb_pend_valid),
    .pend_rd_o      (wb_pend_rd),
    .pend_we_o      (wb_pend_we),
    .retire_valid_o (retire_valid_o),
    .retire_ready_i (retire_ready_i),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o),
    .retire_we_o    (retire_we_o),
    .retire_data_o  (retire_data_o),
    .retire_trap_o  (retire_trap_o)
  );

endmodule

`default_nettype wire

/* sim/tb_core_top.sv */
/*
  Testbench for the RV32I core
  - clock, reset and instruction fetch model that follows redirects
  - retire record checker against the stimulus file
  - one run with steady fetch, one with random fetch gaps and retire stalls
*/
`timescale 1ns/1ps
`default_nettype none

module tb_core_top;
  import core_pkg::*;

  localparam pc_t        RESET_PC       = 32'h0000_0100;
  localparam int         PROG_WORDS     = 64;
  localparam logic [7:0] COUNT_ADDR     = 8'h40;
  localparam int         REC_BASE       = 65;
  localparam int         REC_WORDS      = 5;
  localparam int         MAX_RECORDS    = (256 - REC_BASE) / REC_WORDS;
  localparam int         RETIRE_TIMEOUT = 100;

  logic       clk;
  logic       rst_i;
  logic       fetch_valid_i;
  logic       fetch_ready_o;
  instr_raw_t fetch_instr_i;
  logic       retire_valid_o;
  logic       retire_ready_i;
  pc_t        retire_pc_o;
  raddr_t     retire_rd_o;
  logic       retire_we_o;
  rdata_t     retire_data_o;
  logic       retire_trap_o;
  logic       redirect_o;
  pc_t        redirect_pc_o;

  // Program, record count and expected records
  logic [31:0] stim_mem [256];
  logic [31:0] lfsr;

  core_top #(
    .RESET_PC (RESET_PC)
  ) UUT (
    .clk            (clk),
    .rst_i          (rst_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_ready_o  (fetch_ready_o),
    .fetch_instr_i  (fetch_instr_i),
    .retire_valid_o (retire_valid_o),
    .retire_ready_i (retire_ready_i),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o),
    .retire_we_o    (retire_we_o),
    .retire_data_o  (retire_data_o),
    .retire_trap_o  (retire_trap_o),
    .redirect_o     (redirect_o),
    .redirect_pc_o  (redirect_pc_o)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic draw_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, expected);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("ERROR at %0t ns: %s", $time, reason);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_record(input int idx);
    logic [7:0] base;
    base = 8'(REC_BASE + idx * REC_WORDS);
    // PC first since a wrong-path retire shows up there
    check_value($sformatf("record %0d pc", idx), retire_pc_o, stim_mem[base]);
    check_value($sformatf("record %0d we", idx), 32'(retire_we_o), stim_mem[base + 8'd2]);
    check_value($sformatf("record %0d trap", idx), 32'(retire_trap_o), stim_mem[base + 8'd4]);
    // rd and data only carry meaning with a register write
    if (stim_mem[base + 8'd2] != 32'h0) begin
      check_value($sformatf("record %0d rd", idx), 32'(retire_rd_o), stim_mem[base + 8'd1]);
      check_value($sformatf("record %0d data", idx), retire_data_o, stim_mem[base + 8'd3]);
    end
  endtask

  // Two cycles of reset that end 1 ns after a rising edge
  task automatic apply_reset();
    rst_i          = 1'b1;
    fetch_valid_i  = 1'b0;
    retire_ready_i = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_i = 1'b0;
    check_value("retire_valid_o after reset", 32'(retire_valid_o), 32'h0);
    check_value("redirect_o after reset", 32'(redirect_o), 32'h0);
  endtask

  task automatic run_program(input logic random_mode);
    pc_t  fetch_pc;
    pc_t  offset;
    logic offered;
    logic bit_a;
    logic bit_b;
    int   rec_count;
    int   rec_idx;
    int   idle_cycles;
    rec_count   = int'(stim_mem[COUNT_ADDR]);
    fetch_pc    = RESET_PC;
    offered     = 1'b0;
    rec_idx     = 0;
    idle_cycles = 0;
    apply_reset();
    while (rec_idx < rec_count) begin
      // Offer a new word only once the last one transferred or was redirected
      if (!offered) begin
        bit_a = 1'b1;
        bit_b = 1'b1;
        if (random_mode) begin
          bit_a = draw_bit();
          bit_b = draw_bit();
        end
        if (bit_a || bit_b) begin
          offset = fetch_pc - RESET_PC;
          if ((offset[1:0] != 2'b00) || (offset >= pc_t'(PROG_WORDS * 4))) begin
            abort_run($sformatf("fetch PC %h is outside the program", fetch_pc));
          end
          fetch_instr_i = stim_mem[offset[9:2]];
          fetch_valid_i = 1'b1;
          offered       = 1'b1;
        end else begin
          fetch_valid_i = 1'b0;
        end
      end
      bit_a = 1'b1;
      if (random_mode) begin
        bit_a = draw_bit();
      end
      retire_ready_i = bit_a;

      // Outputs are settled at the falling edge
      @(negedge clk);
      if (retire_valid_o && retire_ready_i) begin
        check_record(rec_idx);
        rec_idx++;
        idle_cycles = 0;
      end else begin
        idle_cycles++;
        if (idle_cycles > RETIRE_TIMEOUT) begin
          abort_run($sformatf("timeout waiting for retire record %0d", rec_idx));
        end
      end
      // A word taken in a redirect cycle is dropped by the core
      if (redirect_o) begin
        fetch_pc = redirect_pc_o;
        offered  = 1'b0;
      end else if (fetch_valid_i && fetch_ready_o) begin
        fetch_pc = fetch_pc + 32'd4;
        offered  = 1'b0;
      end
      @(posedge clk);
      #1;
    end
    fetch_valid_i  = 1'b0;
    retire_ready_i = 1'b0;
  endtask

  initial begin
    rst_i          = 1'b1;
    fetch_valid_i  = 1'b0;
    fetch_instr_i  = '0;
    retire_ready_i = 1'b0;
    lfsr           = 32'hda6e9bdd;
    $readmemh("sim/core_stimulus.txt", stim_mem);
    if ($isunknown(stim_mem[COUNT_ADDR]) || (stim_mem[COUNT_ADDR] == 32'h0) ||
        (stim_mem[COUNT_ADDR] > 32'(MAX_RECORDS))) begin
      abort_run("stimulus file holds no valid record count");
    end

    $display("Run 1: steady fetch, retire always ready");
    run_program(1'b0);
    $display("Run 2: random fetch gaps and retire stalls");
    run_program(1'b1);

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
hw/core_pkg.sv
hw/register_file.sv
hw/decode.sv
hw/execute.sv
hw/writeback.sv
hw/core_top.sv
sim/tb_core_top.sv

/* Makefile */
# Verilator build and run for the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tb_core_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= TEST PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/core_stimulus.txt */
// @00 program words, index (PC - 100) / 4; @40 record count
// Then one record per line: pc rd we data trap (rd, data checked only with we)
@00
FFB00093 00C00113 401101B3 4010D213  // 100 addi x1,-5; addi x2,12; sub x3; srai x4
0020A2B3 0020B333 123453B7 00001417  // 110 slt x5; sltu x6; lui x7; auipc x8
0033C4B3 0040D533 002565B3 0035F633  // 120 xor x9; srl x10; or x11; and x12
01F61693 00C6C463 06300713 00D67463  // 130 slli x13; blt taken; wrong path; bgeu not taken
00C29463 00C28463 06300713 0021D463  // 140 bne not taken; beq taken; wrong path; bge taken
06300713 00316463 06300713 00C007EF  // 150 wrong path; bltu taken; wrong path; jal x15,+12
06300713 06300713 00000817 015808E7  // 160 wrong path x2; auipc x16; jalr x17,21(x16)
06300713 06300713 06300713 0000A903  // 170 wrong path x3; lw x18
0020A223 FFFFFFFF 0FF0000F 00000073  // 180 sw; unknown opcode; fence; ecall
04D00013 00C009B3 01370A33 0000006F  // 190 addi x0,77; add x19,x0,x12; add x20,x14,x19; jal x0,0
00000013
@40
0000001E
00000100 00000001 00000001 FFFFFFFB 00000000
00000104 00000002 00000001 0000000C 00000000
00000108 00000003 00000001 00000011 00000000
0000010C 00000004 00000001 FFFFFFFD 00000000
00000110 00000005 00000001 00000001 00000000
00000114 00000006 00000001 00000000 00000000
00000118 00000007 00000001 12345000 00000000
0000011C 00000008 00000001 0000111C 00000000
00000120 00000009 00000001 12345011 00000000
00000124 0000000A 00000001 00000007 00000000
00000128 0000000B 00000001 0000000F 00000000
0000012C 0000000C 00000001 00000001 00000000
00000130 0000000D 00000001 80000000 00000000
00000134 00000000 00000000 00000000 00000000
0000013C 00000000 00000000 00000000 00000000
00000140 00000000 00000000 00000000 00000000
00000144 00000000 00000000 00000000 00000000
0000014C 00000000 00000000 00000000 00000000
00000154 00000000 00000000 00000000 00000000
0000015C 0000000F 00000001 00000160 00000000
00000168 00000010 00000001 00000168 00000000
0000016C 00000011 00000001 00000170 00000000
0000017C 00000000 00000000 00000000 00000001
00000180 00000000 00000000 00000000 00000001
00000184 00000000 00000000 00000000 00000001
00000188 00000000 00000000 00000000 00000000
0000018C 00000000 00000000 00000000 00000000
00000190 00000000 00000000 00000000 00000000
00000194 00000013 00000001 00000001 00000000
00000198 00000014 00000001 00000001 00000000
